// File: logic/axi_wr_port.sv
//********************************************************************
// write channel port
// one beat through AW then W, counts outstanding responses
//********************************************************************
`timescale 1ns/1ps

module axi_wr_port import pgwr_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       wr_req,
	input  addr_t      wr_addr,
	input  line_t      wr_data,
	input  strb_t      wr_strb,
	input  logic       awready,
	input  logic       wready,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       awvalid,
	output logic       wvalid,
	output addr_t      addr,
	output line_t      data,
	output strb_t      strb,
	output logic       wr_busy,
	output logic       drained,
	output logic       bus_error
);
	logic               aw_hs;
	logic               w_hs;
	logic               accept;
	logic               b_dec;
	logic [OUTST_W-1:0] out_cnt; // AW accepted, response pending

	assign accept = wr_req && !wr_busy;
	assign aw_hs  = awvalid && awready;
	assign w_hs   = wvalid && wready;
	assign b_dec  = bvalid && (out_cnt != '0);

	assign drained = !wr_busy && (out_cnt == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			wr_busy <= 1'b0;
		end else begin
			if (accept) begin
				wr_busy <= 1'b1;
				awvalid <= 1'b1; // address goes out first
			end
			if (aw_hs) begin
				awvalid <= 1'b0;
				wvalid  <= 1'b1;
			end
			if (w_hs) begin
				wvalid  <= 1'b0;
				wr_busy <= 1'b0; // free again next cycle
			end
		end
	end

	// beat held until the W handshake
	always_ff @(posedge clk_i) begin
		if (accept) begin
			addr <= wr_addr;
			data <= wr_data;
			strb <= wr_strb;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_cnt   <= '0;
			bus_error <= 1'b0;
		end else begin
			if (aw_hs && !b_dec)
				out_cnt <= out_cnt + 1'b1;
			else if (b_dec && !aw_hs)
				out_cnt <= out_cnt - 1'b1;
			// sticky on slave error or a stray response
			if (bvalid && (bresp != 2'b00 || out_cnt == '0))
				bus_error <= 1'b1;
		end
	end

endmodule

// File: logic/pgwr_pkg.sv
//********************************************************************
// page-table write manager shared definitions
// table geometry, entry layouts, status and step codes, line helpers
//********************************************************************
package pgwr_pkg;

	// table sizes for this build
	localparam int ATT_ENTRY_CNT  = 16;
	localparam int LIST_ENTRY_CNT = 12; // physical pages on the list
	localparam int LINE_BYTES     = 64;
	localparam int ATT_PER_LINE   = 8;  // 64-bit entries
	localparam int LST_PER_LINE   = 4;  // 128-bit entries
	localparam int OUTST_W        = 7;  // outstanding response counter width

	localparam logic [63:0] ATT_BASE  = 64'h0000_0000_8000_0000;
	localparam logic [63:0] LIST_BASE = 64'h0000_0000_8001_0000;
	localparam logic [49:0] PPA_BASE  = 50'h0_0000_0008_0100; // first page number

	typedef logic [63:0]  addr_t;
	typedef logic [511:0] line_t;
	typedef logic [63:0]  strb_t;
	typedef logic [23:0]  ptr_t;     // entry index, 0 is null
	typedef logic [47:0]  att_way_t;
	typedef logic [11:0]  zpd_cnt_t;

	localparam ptr_t NULL_PTR = 24'd0;

	typedef enum logic [3:0] {
		DALLOC = 4'd1,
		UNCOMP = 4'd2,
		COMP   = 4'd3,
		INCOMP = 4'd4
	} att_sts_t;

	// packed high to low, so sts sits in the low nibble
	typedef struct packed {
		zpd_cnt_t zpd_cnt;
		att_way_t way;
		att_sts_t sts;
	} att_entry_t;

	typedef struct packed {
		logic [5:0]  rsvd;
		logic [49:0] way;
		ptr_t        att_id;
		ptr_t        prev;
		ptr_t        next;   // bytes 0..2 of the slot
	} lst_entry_t;

	typedef enum logic [2:0] {
		INIT_ATT,
		INIT_LST,
		ATT_UPD,
		SRC_POP,
		DST_SELF,
		DST_LINK
	} wr_step_t;

	typedef enum logic [1:0] {
		JOB_INIT_ATT,
		JOB_INIT_LST,
		JOB_UPDATE
	} job_t;

	// line address of att entry n
	function automatic addr_t att_line_addr(ptr_t n);
		ptr_t m;
		m = n - ptr_t'(1);
		return ATT_BASE + addr_t'(m / ATT_PER_LINE) * addr_t'(LINE_BYTES);
	endfunction

	function automatic addr_t lst_line_addr(ptr_t n);
		ptr_t m;
		m = n - ptr_t'(1);
		return LIST_BASE + addr_t'(m / LST_PER_LINE) * addr_t'(LINE_BYTES);
	endfunction

	function automatic logic [2:0] att_lane(ptr_t n);
		ptr_t m;
		m = n - ptr_t'(1);
		return 3'(m % ATT_PER_LINE);
	endfunction

	function automatic logic [1:0] lst_slot(ptr_t n);
		ptr_t m;
		m = n - ptr_t'(1);
		return 2'(m % LST_PER_LINE);
	endfunction

endpackage

// File: logic/pgwr_req_arbiter.sv
//********************************************************************
// request arbiter for the page-table write manager
// picks init att, init list or update by fixed priority
//********************************************************************
`timescale 1ns/1ps

module pgwr_req_arbiter import pgwr_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     init_att,
	input  logic     init_list,
	input  logic     init_att_done,
	input  logic     init_list_done,
	input  logic     upd_valid,
	input  ptr_t     upd_att_id,
	input  ptr_t     upd_lst_id,
	input  ptr_t     upd_next,
	input  att_way_t upd_way,
	input  zpd_cnt_t upd_zpd_cnt,
	input  logic     upd_att_only,
	input  att_sts_t upd_sts,
	input  logic     job_take,
	input  logic     tbl_update_done,
	output logic     job_valid,
	output job_t     job_kind,
	output ptr_t     job_att_id,
	output ptr_t     job_lst_id,
	output ptr_t     job_next,
	output att_way_t job_way,
	output zpd_cnt_t job_zpd_cnt,
	output logic     job_att_only,
	output att_sts_t job_sts
);
	logic upd_mask; // update taken, waiting for its done pulse
	logic att_pend;
	logic lst_pend;
	logic upd_pend;

	assign att_pend = init_att && !init_att_done;
	assign lst_pend = init_list && !init_list_done;
	assign upd_pend = upd_valid && !upd_mask;

	assign job_valid = att_pend || lst_pend || upd_pend;

	always_comb begin
		job_kind = JOB_UPDATE;
		if (att_pend)
			job_kind = JOB_INIT_ATT; // att table first
		else if (lst_pend)
			job_kind = JOB_INIT_LST;
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			upd_mask <= 1'b0;
		end else if (job_take && job_kind == JOB_UPDATE) begin
			upd_mask <= 1'b1;
		end else if (tbl_update_done) begin
			upd_mask <= 1'b0;
		end
	end

	// stable copy for the sequencer while upd_valid stays up
	always_ff @(posedge clk_i) begin
		if (job_take) begin
			job_att_id   <= upd_att_id;
			job_lst_id   <= upd_lst_id;
			job_next     <= upd_next;
			job_way      <= upd_way;
			job_zpd_cnt  <= upd_zpd_cnt;
			job_att_only <= upd_att_only;
			job_sts      <= upd_sts;
		end
	end

endmodule

// File: logic/pgwr_top.sv
//********************************************************************
// page-table write manager top level
// arbiter, write sequencer and write channel port
//********************************************************************
`timescale 1ns/1ps

module pgwr_top import pgwr_pkg::*; (
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       init_att,
	input  logic       init_list,
	input  logic       upd_valid,
	input  ptr_t       upd_att_id,
	input  ptr_t       upd_lst_id,
	input  ptr_t       upd_next,
	input  att_way_t   upd_way,
	input  zpd_cnt_t   upd_zpd_cnt,
	input  logic       upd_att_only,
	input  att_sts_t   upd_sts,
	output logic       awvalid,
	output logic       wvalid,
	output addr_t      addr,
	output line_t      data,
	output strb_t      strb,
	input  logic       awready,
	input  logic       wready,
	input  logic       bvalid,
	input  logic [1:0] bresp,
	output logic       init_att_done,
	output logic       init_list_done,
	output logic       ready,
	output logic       tbl_update_done,
	output logic       bus_error,
	output ptr_t       free_head,
	output ptr_t       free_tail,
	output ptr_t       uncomp_head,
	output ptr_t       uncomp_tail
);
	logic     job_valid;
	job_t     job_kind;
	logic     job_take;
	ptr_t     job_att_id;
	ptr_t     job_lst_id;
	ptr_t     job_next;
	att_way_t job_way;
	zpd_cnt_t job_zpd_cnt;
	logic     job_att_only;
	att_sts_t job_sts;
	logic     wr_req;
	addr_t    wr_addr;
	line_t    wr_data;
	strb_t    wr_strb;
	logic     wr_busy;
	logic     drained;

	pgwr_req_arbiter u_arb (
		.clk_i, .rst_ni,
		.init_att, .init_list,
		.init_att_done, .init_list_done,
		.upd_valid, .upd_att_id, .upd_lst_id, .upd_next,
		.upd_way, .upd_zpd_cnt, .upd_att_only, .upd_sts,
		.job_take, .tbl_update_done,
		.job_valid, .job_kind,
		.job_att_id, .job_lst_id, .job_next,
		.job_way, .job_zpd_cnt, .job_att_only, .job_sts
	);

	tbl_write_seq u_seq (
		.clk_i, .rst_ni,
		.job_valid, .job_kind,
		.job_att_id, .job_lst_id, .job_next,
		.job_way, .job_zpd_cnt, .job_att_only, .job_sts,
		.wr_busy, .drained,
		.job_take, .ready,
		.init_att_done, .init_list_done, .tbl_update_done,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail,
		.wr_req, .wr_addr, .wr_data, .wr_strb
	);

	axi_wr_port u_port (
		.clk_i, .rst_ni,
		.wr_req, .wr_addr, .wr_data, .wr_strb,
		.awready, .wready, .bvalid, .bresp,
		.awvalid, .wvalid, .addr, .data, .strb,
		.wr_busy, .drained, .bus_error
	);

endmodule

// File: logic/tbl_entry_builder.sv
//********************************************************************
// table write builder
// forms line address, data and byte strobes for one table write step
//********************************************************************
`timescale 1ns/1ps

module tbl_entry_builder import pgwr_pkg::*; (
	input  wr_step_t step,
	input  ptr_t     idx,          // init walk counter
	input  ptr_t     job_att_id,
	input  ptr_t     job_lst_id,
	input  ptr_t     job_next,
	input  att_way_t job_way,
	input  zpd_cnt_t job_zpd_cnt,
	input  logic     job_att_only,
	input  att_sts_t job_sts,
	input  ptr_t     uncomp_tail,
	output addr_t    wr_addr,
	output line_t    wr_data,
	output strb_t    wr_strb
);
	ptr_t        tgt;        // entry being written
	logic        is_att;
	att_entry_t  att_e;
	lst_entry_t  lst_e;
	logic [15:0] lst_bytes;  // byte enables inside one list slot
	logic [2:0]  lane;
	logic [1:0]  slot;

	always_comb begin
		tgt       = idx;
		is_att    = 1'b1;
		att_e     = '0;
		lst_e     = '0;
		lst_bytes = '0;
		case (step)
			INIT_ATT: begin
				att_e.sts = DALLOC; // way and count stay 0
			end
			INIT_LST: begin
				is_att       = 1'b0;
				lst_e.way    = PPA_BASE + 50'(idx) - 50'd1;
				lst_e.prev   = idx - ptr_t'(1); // first entry gets null
				lst_e.next   = (idx == ptr_t'(LIST_ENTRY_CNT)) ? NULL_PTR : idx + ptr_t'(1);
				lst_bytes    = 16'hffff;
			end
			ATT_UPD: begin
				tgt           = job_att_id;
				att_e.sts     = job_att_only ? job_sts : UNCOMP;
				att_e.way     = job_way;
				att_e.zpd_cnt = job_zpd_cnt;
			end
			SRC_POP: begin
				// new free head loses its prev link
				is_att     = 1'b0;
				tgt        = job_next;
				lst_e.prev = NULL_PTR;
				lst_bytes  = 16'h0038; // prev only
			end
			DST_SELF: begin
				is_att       = 1'b0;
				tgt          = job_lst_id;
				lst_e.next   = NULL_PTR;
				lst_e.prev   = uncomp_tail;
				lst_e.att_id = job_att_id;
				lst_bytes    = 16'h01ff; // next, prev and att id
			end
			DST_LINK: begin
				is_att     = 1'b0;
				tgt        = uncomp_tail; // old tail points at the new entry
				lst_e.next = job_lst_id;
				lst_bytes  = 16'h0007;
			end
			default: begin
				tgt = idx;
			end
		endcase
	end

	assign lane = att_lane(tgt);
	assign slot = lst_slot(tgt);

	// place the entry in its lane of the line
	always_comb begin
		wr_data = '0;
		wr_strb = '0;
		if (is_att) begin
			wr_addr                 = att_line_addr(tgt);
			wr_data[lane*64 +: 64]  = att_e;
			wr_strb[lane*8 +: 8]    = 8'hff;
		end else begin
			wr_addr                 = lst_line_addr(tgt);
			wr_data[slot*128 +: 128] = lst_e;
			wr_strb[slot*16 +: 16]  = lst_bytes;
		end
	end

endmodule

// File: logic/tbl_write_seq.sv
//********************************************************************
// table write sequencer
// walks init writes and move steps, keeps free and uncompressed
// list head and tail pointers
//********************************************************************
`timescale 1ns/1ps

module tbl_write_seq import pgwr_pkg::*; (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     job_valid,
	input  job_t     job_kind,
	input  ptr_t     job_att_id,
	input  ptr_t     job_lst_id,
	input  ptr_t     job_next,
	input  att_way_t job_way,
	input  zpd_cnt_t job_zpd_cnt,
	input  logic     job_att_only,
	input  att_sts_t job_sts,
	input  logic     wr_busy,
	input  logic     drained,
	output logic     job_take,
	output logic     ready,
	output logic     init_att_done,
	output logic     init_list_done,
	output logic     tbl_update_done,
	output ptr_t     free_head,
	output ptr_t     free_tail,
	output ptr_t     uncomp_head,
	output ptr_t     uncomp_tail,
	output logic     wr_req,
	output addr_t    wr_addr,
	output line_t    wr_data,
	output strb_t    wr_strb
);
	typedef enum logic [2:0] {
		S_IDLE,
		S_INIT,
		S_ATT_UPD,
		S_SRC_POP,
		S_DST_SELF,
		S_DST_LINK,
		S_DRAIN
	} state_t;

	state_t   state;
	job_t     cur_kind;  // kind of the job in service
	ptr_t     ent_cnt;   // init walk, entries start at 1
	ptr_t     last_ent;
	wr_step_t step;
	logic     issuing;

	assign ready    = (state == S_IDLE);
	assign job_take = ready && job_valid;
	assign last_ent = (cur_kind == JOB_INIT_ATT) ? ptr_t'(ATT_ENTRY_CNT)
	                                             : ptr_t'(LIST_ENTRY_CNT);

	// one write per step, only when the port is free
	assign issuing = (state != S_IDLE) && (state != S_DRAIN);
	assign wr_req  = issuing && !wr_busy;

	always_comb begin
		case (state)
			S_INIT:     step = (cur_kind == JOB_INIT_ATT) ? INIT_ATT : INIT_LST;
			S_SRC_POP:  step = SRC_POP;
			S_DST_SELF: step = DST_SELF;
			S_DST_LINK: step = DST_LINK;
			default:    step = ATT_UPD;
		endcase
	end

	tbl_entry_builder u_bld (
		.step         (step),
		.idx          (ent_cnt),
		.job_att_id   (job_att_id),
		.job_lst_id   (job_lst_id),
		.job_next     (job_next),
		.job_way      (job_way),
		.job_zpd_cnt  (job_zpd_cnt),
		.job_att_only (job_att_only),
		.job_sts      (job_sts),
		.uncomp_tail  (uncomp_tail),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.wr_strb      (wr_strb)
	);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state           <= S_IDLE;
			cur_kind        <= JOB_UPDATE;
			ent_cnt         <= NULL_PTR;
			init_att_done   <= 1'b0;
			init_list_done  <= 1'b0;
			tbl_update_done <= 1'b0;
			free_head       <= NULL_PTR;
			free_tail       <= NULL_PTR;
			uncomp_head     <= NULL_PTR;
			uncomp_tail     <= NULL_PTR;
		end else begin
			tbl_update_done <= 1'b0; // single cycle pulse
			case (state)
				S_IDLE: begin
					if (job_valid) begin
						cur_kind <= job_kind;
						ent_cnt  <= ptr_t'(1);
						state    <= (job_kind == JOB_UPDATE) ? S_ATT_UPD : S_INIT;
					end
				end
				S_INIT: begin
					if (wr_req) begin
						ent_cnt <= ent_cnt + ptr_t'(1);
						if (ent_cnt == last_ent)
							state <= S_DRAIN;
					end
				end
				S_ATT_UPD: begin
					if (wr_req) begin
						if (job_att_only) begin
							state <= S_DRAIN;
						end else if (free_head == free_tail) begin
							// last free entry, nothing to unlink
							free_head <= NULL_PTR;
							free_tail <= NULL_PTR;
							state     <= S_DST_SELF;
						end else begin
							state <= S_SRC_POP;
						end
					end
				end
				S_SRC_POP: begin
					if (wr_req) begin
						free_head <= job_next; // pop front
						state     <= S_DST_SELF;
					end
				end
				S_DST_SELF: begin
					if (wr_req) begin
						if (uncomp_tail == NULL_PTR) begin
							uncomp_head <= job_lst_id; // list was empty
							uncomp_tail <= job_lst_id;
							state       <= S_DRAIN;
						end else begin
							state <= S_DST_LINK;
						end
					end
				end
				S_DST_LINK: begin
					if (wr_req) begin
						uncomp_tail <= job_lst_id; // push back
						state       <= S_DRAIN;
					end
				end
				S_DRAIN: begin
					if (drained) begin
						state <= S_IDLE;
						case (cur_kind)
							JOB_INIT_ATT: init_att_done <= 1'b1;
							JOB_INIT_LST: begin
								init_list_done <= 1'b1;
								free_head      <= ptr_t'(1);
								free_tail      <= ptr_t'(LIST_ENTRY_CNT);
							end
							default: tbl_update_done <= 1'b1;
						endcase
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: sim/pgwr_tb.sv
//********************************************************************
// testbench for the page-table write manager
// job table with a bus model, random stalls, reference tables
//********************************************************************
`timescale 1ns/1ps

module pgwr_tb import pgwr_pkg::*; ();
	localparam int CLK_PERIOD  = 8;
	localparam int ROW_CNT     = 10;
	localparam int MAX_JOB_CYC = 16 * 60;  // 16 writes, wide per-write margin
	localparam int RAND_SEED   = 32'h605ff90c;
	localparam logic [1:0] OP_ATT  = 2'd0;
	localparam logic [1:0] OP_LST  = 2'd1;
	localparam logic [1:0] OP_MOVE = 2'd2;
	localparam logic [1:0] OP_ONLY = 2'd3;

	typedef struct packed {
		logic [1:0] op;
		ptr_t       att_id;
		ptr_t       lst_id;
		ptr_t       next;
		att_way_t   way;
		zpd_cnt_t   zpd;
		att_sts_t   sts;
		logic [6:0] stall;   // percent of cycles with ready low
		logic       err;     // first response of the row is SLVERR
		ptr_t       fh;
		ptr_t       ft;
		ptr_t       uh;
		ptr_t       ut;
	} row_t;

	row_t rows [ROW_CNT];

	logic clk_i, rst_ni;
	logic init_att, init_list, upd_valid, upd_att_only;
	ptr_t upd_att_id, upd_lst_id, upd_next;
	att_way_t upd_way;
	zpd_cnt_t upd_zpd_cnt;
	att_sts_t upd_sts;
	logic awvalid, wvalid, awready, wready, bvalid;
	logic [1:0] bresp;
	addr_t addr;
	line_t data;
	strb_t strb;
	logic init_att_done, init_list_done, ready, tbl_update_done, bus_error;
	ptr_t free_head, free_tail, uncomp_head, uncomp_tail;

	logic [7:0]   mem [addr_t];               // byte memory behind the bus
	logic [63:0]  ref_att [1:ATT_ENTRY_CNT];
	logic [127:0] ref_lst [1:LIST_ENTRY_CNT];
	ptr_t rm_ut;                              // model's uncompressed tail
	ptr_t rm_fh, rm_ft;
	bit   att_ready, lst_ready, err_seen;
	int   stall_pct, err_req, err_done, cyc;
	int   aw_pend;                            // addresses taken, data beat owed
	int   b_due [$];                          // response due cycles
	bit   b_err [$];
	int   err_cnt, rows_ok, rows_bad;

	pgwr_top dut0 (
		.clk_i, .rst_ni, .init_att, .init_list,
		.upd_valid, .upd_att_id, .upd_lst_id, .upd_next,
		.upd_way, .upd_zpd_cnt, .upd_att_only, .upd_sts,
		.awvalid, .wvalid, .addr, .data, .strb,
		.awready, .wready, .bvalid, .bresp,
		.init_att_done, .init_list_done, .ready, .tbl_update_done, .bus_error,
		.free_head, .free_tail, .uncomp_head, .uncomp_tail
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// run limit from the row count and the longest job
	initial begin
		#(CLK_PERIOD * (20 + ROW_CNT * MAX_JOB_CYC));
		$display("watchdog expired, a job never finished");
		$display("Regression failed");
		$finish;
	end

	// unwritten bytes read back a pattern folded from the whole address
	function automatic logic [7:0] mem_byte(addr_t a);
		logic [7:0] f;
		if (mem.exists(a))
			return mem[a];
		f = 8'h5a;
		for (int i = 0; i < 8; i++)
			f = f ^ a[i*8 +: 8];
		return f;
	endfunction

	function automatic logic [63:0] read_att(int n);
		addr_t a;
		logic [63:0] v;
		a = ATT_BASE + addr_t'((n - 1) / 8) * 64 + addr_t'((n - 1) % 8) * 8;
		for (int i = 0; i < 8; i++)
			v[i*8 +: 8] = mem_byte(a + addr_t'(i));
		return v;
	endfunction

	function automatic logic [127:0] read_lst(int n);
		addr_t a;
		logic [127:0] v;
		a = LIST_BASE + addr_t'((n - 1) / 4) * 64 + addr_t'((n - 1) % 4) * 16;
		for (int i = 0; i < 16; i++)
			v[i*8 +: 8] = mem_byte(a + addr_t'(i));
		return v;
	endfunction

	function automatic bit job_finished(logic [1:0] op);
		case (op)
			OP_ATT:  return init_att_done;
			OP_LST:  return init_list_done;
			default: return tbl_update_done;
		endcase
	endfunction

	function automatic string op_name(logic [1:0] op);
		case (op)
			OP_ATT:  return "init att";
			OP_LST:  return "init list";
			OP_MOVE: return "move";
			default: return "att only";
		endcase
	endfunction

	// slave side of the write channel
	initial begin
		bit inj;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bresp   = 2'b00;
		void'($urandom(RAND_SEED));
		forever begin
			@(posedge clk_i);
			if (rst_ni) begin
				cyc = cyc + 1;
				if (awvalid && awready)
					aw_pend++;
				if (wvalid && wready) begin
					if (aw_pend == 0) begin
						$display("data beat accepted before its address");
						err_cnt++;
					end else begin
						aw_pend--;
					end
					for (int i = 0; i < LINE_BYTES; i++)
						if (strb[i])
							mem[addr + addr_t'(i)] = data[i*8 +: 8];
					inj = (err_req != err_done);
					if (inj)
						err_done++;
					b_err.push_back(inj);
					b_due.push_back(stall_pct == 0 ? cyc + 1 : cyc + 1 + $urandom_range(6));
				end
				if (b_due.size() > 0 && b_due[0] <= cyc) begin
					bvalid <= 1'b1;
					bresp  <= b_err[0] ? 2'b10 : 2'b00; // SLVERR when injected
					void'(b_due.pop_front());
					void'(b_err.pop_front());
				end else begin
					bvalid <= 1'b0;
					bresp  <= 2'b00;
				end
				awready <= ($urandom_range(99) >= stall_pct);
				wready  <= ($urandom_range(99) >= stall_pct);
			end
		end
	end

	task automatic load_rows();
		// op, att, lst, next, way, zpd, sts, stall, err, fh, ft, uh, ut
		rows[0] = '{OP_ATT, 0, 0, 0, 0, 0, DALLOC, 0, 0, 0, 0, 0, 0};
		rows[1] = '{OP_LST, 0, 0, 0, 0, 0, DALLOC, 0, 0, 1, 12, 0, 0};
		rows[2] = '{OP_MOVE, 3, 1, 2, 48'h0102_0304, 12'h005, COMP, 0, 0, 2, 12, 1, 1};
		rows[3] = '{OP_MOVE, 7, 2, 3, 48'h0a0b_0c0d, 12'h011, COMP, 0, 0, 3, 12, 1, 2};
		rows[4] = '{OP_ONLY, 5, 0, 0, 48'h00ab_cdef, 12'h03a, COMP, 0, 0, 3, 12, 1, 2};
		rows[5] = '{OP_MOVE, 9, 3, 4, 48'h1111_2222, 12'h0ff, INCOMP, 40, 0, 4, 12, 1, 3};
		rows[6] = '{OP_ONLY, 12, 0, 0, 48'h3333_4444, 12'h100, INCOMP, 50, 0, 4, 12, 1, 3};
		rows[7] = '{OP_MOVE, 16, 4, 5, 48'h5555_6666, 12'h7ff, COMP, 30, 0, 5, 12, 1, 4};
		rows[8] = '{OP_MOVE, 1, 5, 6, 48'h7777_8888, 12'h001, COMP, 20, 1, 6, 12, 1, 5};
		rows[9] = '{OP_ONLY, 2, 0, 0, 48'h9999_aaaa, 12'h222, DALLOC, 25, 0, 6, 12, 1, 5};
	endtask

	task automatic apply_row(input row_t rw);
		stall_pct <= rw.stall;
		if (rw.err)
			err_req <= err_req + 1;
		case (rw.op)
			OP_ATT: init_att <= 1'b1;   // levels stay up, done masks them
			OP_LST: init_list <= 1'b1;
			default: begin
				upd_att_id   <= rw.att_id;
				upd_lst_id   <= rw.lst_id;
				upd_next     <= rw.next;
				upd_way      <= rw.way;
				upd_zpd_cnt  <= rw.zpd;
				upd_att_only <= (rw.op == OP_ONLY);
				upd_sts      <= rw.sts;
				upd_valid    <= 1'b1;
			end
		endcase
		@(posedge clk_i);
		while (!job_finished(rw.op))
			@(posedge clk_i);
		upd_valid <= 1'b0; // dropped right after the done pulse
	endtask

	task automatic model_row(input row_t rw);
		case (rw.op)
			OP_ATT: begin
				for (int n = 1; n <= ATT_ENTRY_CNT; n++)
					ref_att[n] = {12'd0, 48'd0, DALLOC};
				att_ready = 1'b1;
			end
			OP_LST: begin
				for (int n = 1; n <= LIST_ENTRY_CNT; n++) begin
					ref_lst[n]          = '0;
					ref_lst[n][23:0]    = (n == LIST_ENTRY_CNT) ? 24'd0 : 24'(n + 1);
					ref_lst[n][47:24]   = 24'(n - 1);
					ref_lst[n][121:72]  = PPA_BASE + 50'(n - 1);
				end
				rm_fh     = 1;
				rm_ft     = LIST_ENTRY_CNT;
				lst_ready = 1'b1;
			end
			OP_ONLY: ref_att[rw.att_id] = {rw.zpd, rw.way, rw.sts};
			default: begin
				ref_att[rw.att_id] = {rw.zpd, rw.way, UNCOMP};
				if (rm_fh == rm_ft) begin
					rm_fh = 0;
					rm_ft = 0;
				end else begin
					ref_lst[rw.next][47:24] = 24'd0; // new free head has no prev
					rm_fh = rw.next;
				end
				ref_lst[rw.lst_id][23:0]  = 24'd0;
				ref_lst[rw.lst_id][47:24] = rm_ut;
				ref_lst[rw.lst_id][71:48] = rw.att_id;
				if (rm_ut != 0)
					ref_lst[rm_ut][23:0] = rw.lst_id; // old tail links forward
				rm_ut = rw.lst_id;
			end
		endcase
		if (rw.err)
			err_seen = 1'b1;
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
	                               input logic [127:0] exp);
		$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
		err_cnt++;
	endtask

	task automatic check_row(input int r, input row_t rw, input int errs_before);
		if (free_head !== rw.fh)
			report_mismatch("free_head", free_head, rw.fh);
		if (free_tail !== rw.ft)
			report_mismatch("free_tail", free_tail, rw.ft);
		if (uncomp_head !== rw.uh)
			report_mismatch("uncomp_head", uncomp_head, rw.uh);
		if (uncomp_tail !== rw.ut)
			report_mismatch("uncomp_tail", uncomp_tail, rw.ut);
		if (ready !== 1'b1)
			report_mismatch("ready", ready, 1'b1);
		if (init_att_done !== att_ready)
			report_mismatch("init_att_done", init_att_done, att_ready);
		if (init_list_done !== lst_ready)
			report_mismatch("init_list_done", init_list_done, lst_ready);
		if (bus_error !== err_seen)
			report_mismatch("bus_error", bus_error, err_seen);
		if (aw_pend != 0) begin
			$display("address accepted with no data beat after it");
			err_cnt++;
		end
		for (int n = 1; n <= ATT_ENTRY_CNT; n++)
			if (att_ready && read_att(n) !== ref_att[n])
				report_mismatch($sformatf("att[%0d]", n), read_att(n), ref_att[n]);
		for (int n = 1; n <= LIST_ENTRY_CNT; n++)
			if (lst_ready && read_lst(n) !== ref_lst[n])
				report_mismatch($sformatf("lst[%0d]", n), read_lst(n), ref_lst[n]);
		if (err_cnt == errs_before) begin
			rows_ok++;
			$display("row %0d %s: ok", r, op_name(rw.op));
		end else begin
			rows_bad++;
			$display("row %0d %s: %0d mismatches", r, op_name(rw.op), err_cnt - errs_before);
		end
	endtask

	initial begin
		int row_err_base;
		rst_ni       = 1'b0;
		init_att     = 1'b0;
		init_list    = 1'b0;
		upd_valid    = 1'b0;
		upd_att_id   = '0;
		upd_lst_id   = '0;
		upd_next     = '0;
		upd_way      = '0;
		upd_zpd_cnt  = '0;
		upd_att_only = 1'b0;
		upd_sts      = DALLOC;
		stall_pct    = 0;
		err_req      = 0;
		err_done     = 0;
		cyc          = 0;
		aw_pend      = 0;
		err_cnt      = 0;
		rows_ok      = 0;
		rows_bad     = 0;
		rm_fh        = '0;
		rm_ft        = '0;
		rm_ut        = '0;
		att_ready    = 1'b0;
		lst_ready    = 1'b0;
		err_seen     = 1'b0;
		load_rows();
		repeat (8) @(posedge clk_i);
		rst_ni <= 1'b1;
		for (int r = 0; r < ROW_CNT; r++) begin
			row_err_base = err_cnt;
			apply_row(rows[r]);
			model_row(rows[r]);
			check_row(r, rows[r], row_err_base);
			@(posedge clk_i); // idle cycle between jobs
		end
		if (dut0.u_port.props0.fails != 0)
			$display("port handshake assertions failed %0d times", dut0.u_port.props0.fails);
		$display("%0d rows: %0d ok, %0d with mismatches, %0d errors, %0d assertion failures",
		         ROW_CNT, rows_ok, rows_bad, err_cnt, dut0.u_port.props0.fails);
		if (err_cnt == 0 && dut0.u_port.props0.fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: sim/pgwr_tb_properties.sv
//********************************************************************
// write channel port rules
// stable beats under stall, W after AW, sticky bus error
//********************************************************************
`timescale 1ns/1ps

module pgwr_tb_properties import pgwr_pkg::*; (
	input logic  clk_i,
	input logic  rst_ni,
	input logic  awvalid,
	input logic  awready,
	input logic  wvalid,
	input logic  wready,
	input logic  bus_error,
	input addr_t addr,
	input line_t data,
	input strb_t strb
);
	int fails = 0; // failure tally, summed by the testbench

	aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		awvalid && !awready |=> awvalid && $stable(addr) && $stable(data) && $stable(strb))
	else begin
		$error("awvalid or beat changed while AW stalled");
		fails++;
	end

	w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wvalid && !wready |=> wvalid && $stable(addr) && $stable(data) && $stable(strb))
	else begin
		$error("wvalid or beat changed while W stalled");
		fails++;
	end

	// W only follows an accepted address
	w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$rose(wvalid) |-> $past(awvalid && awready))
	else begin
		$error("wvalid raised without an AW handshake");
		fails++;
	end

	err_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
		bus_error |=> bus_error)
	else begin
		$error("bus_error cleared");
		fails++;
	end

endmodule

bind axi_wr_port pgwr_tb_properties props0 (
	.clk_i     (clk_i),
	.rst_ni    (rst_ni),
	.awvalid   (awvalid),
	.awready   (awready),
	.wvalid    (wvalid),
	.wready    (wready),
	.bus_error (bus_error),
	.addr      (addr),
	.data      (data),
	.strb      (strb)
);

// File: src.f
logic/pgwr_pkg.sv
logic/pgwr_req_arbiter.sv
logic/tbl_entry_builder.sv
logic/tbl_write_seq.sv
logic/axi_wr_port.sv
logic/pgwr_top.sv
sim/pgwr_tb_properties.sv
sim/pgwr_tb.sv
